//--- source/cnn_consts.svh
`ifndef CNN_CONSTS_SVH
`define CNN_CONSTS_SVH

// --------------------
// data format
// --------------------

// pixel, weight and activation width
`define CNN_DATA_W      16
// fraction bits of the Q8.8 format
`define CNN_FRAC_BITS   8
// accumulator width, leaves headroom for the product sums
`define CNN_ACC_W       40

// --------------------
// map and layer sizes
// --------------------

// side of the incoming feature map
`define CNN_IN_SIZE     4
// side after 2x2 pooling
`define CNN_POOL_SIZE   2
// flattened length fed to fc1
`define CNN_FLAT_N      4
// fc1 hidden nodes
`define CNN_FC1_NODES   4
// fc2 class count
`define CNN_CLASSES     10

// --------------------
// index widths
// --------------------

// raster row and column counters
`define CNN_POS_W       2
// flatten buffer index
`define CNN_FLAT_IDX_W  2
// node index, wide enough for the class count
`define CNN_NODE_W      4
// tap index within one node
`define CNN_TAP_W       2
// class index in a result
`define CNN_CLASS_W     4

`endif

//--- source/cnn_pkg.sv
`include "cnn_consts.svh"

package cnn_pkg;

   // --------------------
   // scalar types
   // --------------------

   // signed Q8.8 word for pixels, weights and activations
   typedef logic signed [`CNN_DATA_W-1:0] pixel_t;

   // layer a weight or a result belongs to
   typedef enum logic {
      FC1,
      FC2
   } layer_op_t;

   // fc engine sequencing
   typedef enum logic [2:0] {
      IDLE,
      FC1_MAC,
      FC1_STORE,
      FC2_MAC,
      FC2_STORE,
      DONE
   } fc_state_t;

   // --------------------
   // records
   // --------------------

   // one weight load request
   typedef struct packed {
      layer_op_t                layer;
      logic [`CNN_NODE_W-1:0]   node;
      logic [`CNN_TAP_W-1:0]    tap;
      pixel_t                   value;
   } weight_wr_t;

   // one pooled sample with its place in the flattened vector
   typedef struct packed {
      logic [`CNN_FLAT_IDX_W-1:0] idx;
      pixel_t                     value;
   } pooled_t;

   // one fc2 output
   typedef struct packed {
      logic [`CNN_CLASS_W-1:0]  cls;
      pixel_t                   score;
   } class_result_t;

endpackage

//--- source/max_pool_2x2.sv
`timescale 1ns/100ps
`include "cnn_consts.svh"

module max_pool_2x2 import cnn_pkg::*; (
   input  logic    clk,
   input  logic    rst,
   input  logic    pix_valid,
   input  pixel_t  pix,
   output logic    pool_valid,
   output pooled_t pool_out
);

   // raster position of the incoming pixel
   logic [`CNN_POS_W-1:0]      row;
   logic [`CNN_POS_W-1:0]      col;
   logic                       row_last;
   logic                       col_last;
   // pooled column, selects the line buffer slot
   logic [`CNN_POS_W-2:0]      pcol;
   logic [`CNN_FLAT_IDX_W-1:0] flat_idx;
   // even-column pixel, waiting for its right neighbour
   pixel_t                     prev_pix;
   // horizontal maxima of the even row above
   pixel_t                     line_max [`CNN_POOL_SIZE];
   pixel_t                     pair_max;
   // bottom-right pixel of a window
   logic                       win_done;

   function automatic pixel_t smax(input pixel_t a, input pixel_t b);
      return (a > b) ? a : b;
   endfunction

   assign row_last = (row == `CNN_POS_W'(`CNN_IN_SIZE - 1));
   assign col_last = (col == `CNN_POS_W'(`CNN_IN_SIZE - 1));
   assign pcol     = col[`CNN_POS_W-1:1];
   assign pair_max = smax(prev_pix, pix);
   assign win_done = pix_valid & row[0] & col[0];

   // row major position in the pooled map
   assign flat_idx = `CNN_FLAT_IDX_W'((row >> 1) * `CNN_POOL_SIZE + pcol);

   // --------------------
   // raster counters
   // --------------------

   always_ff @(posedge clk) begin
      if (rst) begin
         row <= '0;
         col <= '0;
      end else if (pix_valid) begin
         if (col_last) begin
            col <= '0;
            // wrap back to the top for the next image
            row <= row_last ? '0 : row + 1'b1;
         end else begin
            col <= col + 1'b1;
         end
      end
   end

   // --------------------
   // window maxima
   // --------------------

   // even column holds the pixel, odd column of an even row fills the line buffer
   always_ff @(posedge clk) begin
      if (pix_valid) begin
         if (!col[0]) begin
            prev_pix <= pix;
         end else if (!row[0]) begin
            line_max[pcol] <= pair_max;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         pool_valid <= 1'b0;
      end else begin
         pool_valid <= win_done;
      end
   end

   // combine the upper pair with the current pair
   always_ff @(posedge clk) begin
      if (win_done) begin
         pool_out.idx   <= flat_idx;
         pool_out.value <= smax(line_max[pcol], pair_max);
      end
   end

endmodule

//--- source/flatten_buffer.sv
`timescale 1ns/100ps
`include "cnn_consts.svh"

module flatten_buffer import cnn_pkg::*; (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       pool_valid,
   input  pooled_t                    pool_out,
   input  logic [`CNN_FLAT_IDX_W-1:0] flat_rd_idx,
   output pixel_t                     flat_rd_data,
   output logic                       fc_start
);

   // flattened pooled map of the current image
   pixel_t                     flat_mem [`CNN_FLAT_N];
   // writes seen for this image
   logic [`CNN_FLAT_IDX_W-1:0] wr_cnt;
   logic                       wr_last;

   assign wr_last = (wr_cnt == `CNN_FLAT_IDX_W'(`CNN_FLAT_N - 1));

   always_ff @(posedge clk) begin
      if (pool_valid) begin
         flat_mem[pool_out.idx] <= pool_out.value;
      end
      // one cycle read latency toward the fc engine
      flat_rd_data <= flat_mem[flat_rd_idx];
   end

   // count writes, fire once on the last one and rearm
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_cnt   <= '0;
         fc_start <= 1'b0;
      end else begin
         fc_start <= pool_valid & wr_last;
         if (pool_valid) begin
            wr_cnt <= wr_last ? '0 : wr_cnt + 1'b1;
         end
      end
   end

endmodule

//--- source/weight_store.sv
`timescale 1ns/100ps
`include "cnn_consts.svh"

module weight_store import cnn_pkg::*; (
   input  logic                   clk,
   input  logic                   wt_valid,
   input  weight_wr_t             wt,
   input  layer_op_t              w_rd_layer,
   input  logic [`CNN_NODE_W-1:0] w_rd_node,
   input  logic [`CNN_TAP_W-1:0]  w_rd_tap,
   output pixel_t                 w_rd_data
);

   localparam int FC1_DEPTH = `CNN_FC1_NODES * `CNN_FLAT_N;
   localparam int FC2_DEPTH = `CNN_CLASSES * `CNN_FC1_NODES;
   localparam int FC1_AW    = $clog2(FC1_DEPTH);
   localparam int FC2_AW    = $clog2(FC2_DEPTH);

   // node major, one row of taps per node
   pixel_t              fc1_mem [FC1_DEPTH];
   pixel_t              fc2_mem [FC2_DEPTH];

   logic [FC1_AW-1:0]   wr_addr1;
   logic [FC2_AW-1:0]   wr_addr2;
   logic [FC1_AW-1:0]   rd_addr1;
   logic [FC2_AW-1:0]   rd_addr2;

   // fc1 rows hold one tap per flattened value, fc2 rows one per hidden node
   assign wr_addr1 = FC1_AW'(wt.node * `CNN_FLAT_N + wt.tap);
   assign wr_addr2 = FC2_AW'(wt.node * `CNN_FC1_NODES + wt.tap);
   assign rd_addr1 = FC1_AW'(w_rd_node * `CNN_FLAT_N + w_rd_tap);
   assign rd_addr2 = FC2_AW'(w_rd_node * `CNN_FC1_NODES + w_rd_tap);

   // --------------------
   // load port
   // --------------------

   always_ff @(posedge clk) begin
      if (wt_valid) begin
         if (wt.layer == FC1) begin
            fc1_mem[wr_addr1] <= wt.value;
         end else begin
            fc2_mem[wr_addr2] <= wt.value;
         end
      end
   end

   // --------------------
   // engine read port
   // --------------------

   always_ff @(posedge clk) begin
      w_rd_data <= (w_rd_layer == FC1) ? fc1_mem[rd_addr1] : fc2_mem[rd_addr2];
   end

endmodule

//--- source/fc_engine.sv
`timescale 1ns/100ps
`include "cnn_consts.svh"

module fc_engine import cnn_pkg::*; (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       fc_start,
   input  pixel_t                     flat_rd_data,
   input  pixel_t                     w_rd_data,
   output logic [`CNN_FLAT_IDX_W-1:0] flat_rd_idx,
   output layer_op_t                  w_rd_layer,
   output logic [`CNN_NODE_W-1:0]     w_rd_node,
   output logic [`CNN_TAP_W-1:0]      w_rd_tap,
   output logic                       res_valid,
   output class_result_t              res,
   output logic                       frame_done,
   output logic                       busy
);

   // tap counts per layer, the counter runs one past for the read latency
   localparam logic [`CNN_TAP_W:0]    FC1_TAPS = `CNN_FLAT_N;
   localparam logic [`CNN_TAP_W:0]    FC2_TAPS = `CNN_FC1_NODES;
   localparam logic [`CNN_NODE_W-1:0] FC1_LAST = `CNN_FC1_NODES - 1;
   localparam logic [`CNN_NODE_W-1:0] FC2_LAST = `CNN_CLASSES - 1;
   // 16 bit signed limits in accumulator width
   localparam logic signed [`CNN_ACC_W-1:0] SAT_MAX = 2 ** (`CNN_DATA_W - 1) - 1;
   localparam logic signed [`CNN_ACC_W-1:0] SAT_MIN = -(2 ** (`CNN_DATA_W - 1));

   fc_state_t                         state;
   logic [`CNN_NODE_W-1:0]            node_cnt;
   logic [`CNN_TAP_W:0]               tap_cnt;
   logic [`CNN_TAP_W:0]               tap_n;
   logic                              in_mac;
   logic                              in_fc2;
   // a read was issued last cycle, its data is on the ports now
   logic                              mac_en;
   // relu outputs of fc1
   pixel_t                            hidden [`CNN_FC1_NODES];
   pixel_t                            hid_rd;
   pixel_t                            operand;
   logic signed [2*`CNN_DATA_W-1:0]   product;
   logic signed [`CNN_ACC_W-1:0]      acc;
   pixel_t                            sat_val;

   // drop the fraction bits of the product sum and clamp to 16 bits
   function automatic pixel_t saturate(input logic signed [`CNN_ACC_W-1:0] v);
      logic signed [`CNN_ACC_W-1:0] s;
      s = v >>> `CNN_FRAC_BITS;
      if (s > SAT_MAX) begin
         s = SAT_MAX;
      end else if (s < SAT_MIN) begin
         s = SAT_MIN;
      end
      return pixel_t'(s);
   endfunction

   assign in_mac  = (state == FC1_MAC) || (state == FC2_MAC);
   assign in_fc2  = (state == FC2_MAC) || (state == FC2_STORE);
   assign tap_n   = in_fc2 ? FC2_TAPS : FC1_TAPS;
   // hidden registers stand in for the flatten buffer during fc2
   assign operand = in_fc2 ? hid_rd : flat_rd_data;
   assign product = operand * w_rd_data;
   assign sat_val = saturate(acc);

   assign flat_rd_idx = tap_cnt[`CNN_FLAT_IDX_W-1:0];
   assign w_rd_tap    = tap_cnt[`CNN_TAP_W-1:0];
   assign w_rd_node   = node_cnt;
   assign w_rd_layer  = in_fc2 ? FC2 : FC1;
   // high from the start pulse until the decision is presented
   assign busy        = fc_start | frame_done | (state != IDLE);

   // --------------------
   // sequencing
   // --------------------

   always_ff @(posedge clk) begin
      if (rst) begin
         state      <= IDLE;
         node_cnt   <= '0;
         tap_cnt    <= '0;
         res_valid  <= 1'b0;
         frame_done <= 1'b0;
      end else begin
         res_valid  <= 1'b0;
         frame_done <= 1'b0;
         case (state)
            IDLE: begin
               if (fc_start) begin
                  state    <= FC1_MAC;
                  node_cnt <= '0;
                  tap_cnt  <= '0;
               end
            end
            FC1_MAC: begin
               if (tap_cnt == tap_n) begin
                  tap_cnt <= '0;
                  state   <= FC1_STORE;
               end else begin
                  tap_cnt <= tap_cnt + 1'b1;
               end
            end
            FC1_STORE: begin
               if (node_cnt == FC1_LAST) begin
                  node_cnt <= '0;
                  state    <= FC2_MAC;
               end else begin
                  node_cnt <= node_cnt + 1'b1;
                  state    <= FC1_MAC;
               end
            end
            FC2_MAC: begin
               if (tap_cnt == tap_n) begin
                  tap_cnt <= '0;
                  state   <= FC2_STORE;
               end else begin
                  tap_cnt <= tap_cnt + 1'b1;
               end
            end
            FC2_STORE: begin
               res_valid <= 1'b1;
               if (node_cnt == FC2_LAST) begin
                  node_cnt <= '0;
                  state    <= DONE;
               end else begin
                  node_cnt <= node_cnt + 1'b1;
                  state    <= FC2_MAC;
               end
            end
            DONE: begin
               // last class already went out one cycle earlier
               frame_done <= 1'b1;
               state      <= IDLE;
            end
            default: state <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         mac_en <= 1'b0;
      end else begin
         mac_en <= in_mac && (tap_cnt != tap_n);
      end
   end

   // --------------------
   // datapath
   // --------------------

   always_ff @(posedge clk) begin
      // sum restarts outside the mac phases
      if (!in_mac) begin
         acc <= '0;
      end else if (mac_en) begin
         acc <= acc + product;
      end
      // same latency as the flatten and weight reads
      hid_rd <= hidden[tap_cnt[`CNN_TAP_W-1:0]];
      if (state == FC1_STORE) begin
         hidden[node_cnt[`CNN_TAP_W-1:0]] <= sat_val[`CNN_DATA_W-1] ? '0 : sat_val;
      end
      if (state == FC2_STORE) begin
         res.cls   <= node_cnt;
         res.score <= sat_val;
      end
   end

endmodule

//--- source/class_decision.sv
`timescale 1ns/100ps
`include "cnn_consts.svh"

module class_decision import cnn_pkg::*; (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    res_valid,
   input  class_result_t           res,
   input  logic                    frame_done,
   output logic [`CNN_CLASSES-1:0] out,
   output logic                    out_valid
);

   // sign bits gathered while fc2 runs
   logic [`CNN_CLASSES-1:0] staging;

   // --------------------
   // staging
   // --------------------

   always_ff @(posedge clk) begin
      if (rst) begin
         staging <= '0;
      end else if (res_valid) begin
         // negative score sets the class bit
         staging[res.cls] <= res.score[`CNN_DATA_W-1];
      end
   end

   // --------------------
   // presentation
   // --------------------

   // whole vector moves at once, out holds until the next image
   always_ff @(posedge clk) begin
      if (rst) begin
         out       <= '0;
         out_valid <= 1'b0;
      end else begin
         out_valid <= frame_done;
         if (frame_done) begin
            out <= staging;
         end
      end
   end

endmodule

//--- source/cnn_classifier_top.sv
`timescale 1ns/100ps
`include "cnn_consts.svh"

module cnn_classifier_top import cnn_pkg::*; (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    pix_valid,
   input  pixel_t                  pix,
   input  logic                    wt_valid,
   input  weight_wr_t              wt,
   output logic [`CNN_CLASSES-1:0] out,
   output logic                    out_valid,
   output logic                    busy
);

   // --------------------
   // input side
   // --------------------

   logic                       pool_valid;
   pooled_t                    pool_out;
   logic                       fc_start;
   logic [`CNN_FLAT_IDX_W-1:0] flat_rd_idx;
   pixel_t                     flat_rd_data;

   // --------------------
   // processing
   // --------------------

   layer_op_t                  w_rd_layer;
   logic [`CNN_NODE_W-1:0]     w_rd_node;
   logic [`CNN_TAP_W-1:0]      w_rd_tap;
   pixel_t                     w_rd_data;

   // --------------------
   // output side
   // --------------------

   logic                       res_valid;
   class_result_t              res;
   logic                       frame_done;

   max_pool_2x2 u_pool (
      .clk        (clk),
      .rst        (rst),
      .pix_valid  (pix_valid),
      .pix        (pix),
      .pool_valid (pool_valid),
      .pool_out   (pool_out)
   );

   flatten_buffer u_flat (
      .clk          (clk),
      .rst          (rst),
      .pool_valid   (pool_valid),
      .pool_out     (pool_out),
      .flat_rd_idx  (flat_rd_idx),
      .flat_rd_data (flat_rd_data),
      .fc_start     (fc_start)
   );

   weight_store u_wts (
      .clk        (clk),
      .wt_valid   (wt_valid),
      .wt         (wt),
      .w_rd_layer (w_rd_layer),
      .w_rd_node  (w_rd_node),
      .w_rd_tap   (w_rd_tap),
      .w_rd_data  (w_rd_data)
   );

   fc_engine u_fc (
      .clk          (clk),
      .rst          (rst),
      .fc_start     (fc_start),
      .flat_rd_data (flat_rd_data),
      .w_rd_data    (w_rd_data),
      .flat_rd_idx  (flat_rd_idx),
      .w_rd_layer   (w_rd_layer),
      .w_rd_node    (w_rd_node),
      .w_rd_tap     (w_rd_tap),
      .res_valid    (res_valid),
      .res          (res),
      .frame_done   (frame_done),
      .busy         (busy)
   );

   class_decision u_dec (
      .clk        (clk),
      .rst        (rst),
      .res_valid  (res_valid),
      .res        (res),
      .frame_done (frame_done),
      .out        (out),
      .out_valid  (out_valid)
   );

endmodule

//--- tb/tb_cnn_classifier.sv
`timescale 1ns/100ps
`include "cnn_consts.svh"

module tb_cnn_classifier import cnn_pkg::*; ();

   localparam int CLK_HALF   = 10;
   localparam int RST_CYCLES = 10;
   // allowance per image from the last pixel to out_valid
   localparam int IMG_CYCLES = 200;

   // one parsed line of the trace
   typedef struct packed {
      logic [7:0]       kind;
      logic [15:0]      a;
      logic [15:0]      b;
      logic [3:0][15:0] vals;
   } trace_rec_t;

   logic                    clk;
   logic                    rst;
   logic                    pix_valid;
   pixel_t                  pix;
   logic                    wt_valid;
   weight_wr_t              wt;
   logic [`CNN_CLASSES-1:0] out;
   logic                    out_valid;
   logic                    busy;

   trace_rec_t              recs [$];
   // last expected decision, out must hold it between pulses
   logic [`CNN_CLASSES-1:0] held_out;
   int                      pulse_cnt;
   int                      img_cnt;
   int                      check_cnt;
   int                      limit_cycles;

   cnn_classifier_top UUT (
      .clk       (clk),
      .rst       (rst),
      .pix_valid (pix_valid),
      .pix       (pix),
      .wt_valid  (wt_valid),
      .wt        (wt),
      .out       (out),
      .out_valid (out_valid),
      .busy      (busy)
   );

   initial begin
      clk = 1'b0;
      forever #CLK_HALF clk = ~clk;
   end

   // --------------------
   // checking
   // --------------------

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         $display("MISMATCH at %0t ns: %s expected %h actual %h", $time, name, expected, actual);
         $display("tests failed");
         $fatal(1, "stopped at first error");
      end else begin
         check_cnt = check_cnt + 1;
      end
   endtask

   task automatic stop_with_error(input string why);
      $display("%s", why);
      $display("tests failed");
      $fatal(1, "%s", why);
   endtask

   // out stays put unless a new decision is presented
   always @(negedge clk) begin
      if (!rst) begin
         if (out_valid) begin
            pulse_cnt = pulse_cnt + 1;
         end else begin
            check_value("out", 32'(out), 32'(held_out));
         end
      end
   end

   // --------------------
   // trace file
   // --------------------

   task automatic read_trace();
      int          fd;
      int          n;
      byte         c;
      string       line;
      logic [15:0] a;
      logic [15:0] b;
      logic [15:0] v0;
      logic [15:0] v1;
      logic [15:0] v2;
      logic [15:0] v3;
      trace_rec_t  r;
      fd = $fopen("tb/classifier_trace.txt", "r");
      if (fd == 0) begin
         stop_with_error("cannot open tb/classifier_trace.txt");
      end else begin
         while ($fgets(line, fd) != 0) begin
            a  = '0;
            b  = '0;
            v0 = '0;
            v1 = '0;
            v2 = '0;
            v3 = '0;
            n  = 0;
            c  = line.getc(0);
            case (c)
               "w": n = $sscanf(line, "w %h %h %h %h %h %h", a, b, v0, v1, v2, v3) - 2;
               "p": n = $sscanf(line, "p %h %h %h %h", v0, v1, v2, v3);
               "e": n = $sscanf(line, "e %h", a) + 3;
               "#", "\n", " ": n = -1;
               default: stop_with_error({"unknown trace record: ", line});
            endcase
            // w, p and e records all carry four fields after adjustment
            if (n >= 0) begin
               if (n != 4) begin
                  stop_with_error({"malformed trace line: ", line});
               end
               r.kind = c;
               r.a    = a;
               r.b    = b;
               r.vals = {v3, v2, v1, v0};
               recs.push_back(r);
            end
         end
         $fclose(fd);
      end
   endtask

   // --------------------
   // stimulus
   // --------------------

   task automatic load_weight_row(input trace_rec_t r);
      for (int t = 0; t < 4; t++) begin
         @(negedge clk);
         // weights only go in while the engine is idle
         check_value("busy", 32'(busy), 32'd0);
         wt_valid    = 1'b1;
         wt.layer    = r.a[0] ? FC2 : FC1;
         wt.node     = r.b[`CNN_NODE_W-1:0];
         wt.tap      = `CNN_TAP_W'(t);
         wt.value    = r.vals[t];
      end
      @(negedge clk);
      wt_valid = 1'b0;
   endtask

   task automatic send_pixel_row(input trace_rec_t r);
      for (int x = 0; x < `CNN_IN_SIZE; x++) begin
         @(negedge clk);
         // engine stays idle until the image is complete
         check_value("busy", 32'(busy), 32'd0);
         pix_valid = 1'b1;
         pix       = r.vals[x];
      end
   endtask

   // image may only start when idle and after exactly one pulse per image
   task automatic check_image_start();
      check_value("busy", 32'(busy), 32'd0);
      check_value("out_valid pulse count", 32'(pulse_cnt), 32'(img_cnt));
   endtask

   task automatic collect_result(input logic [`CNN_CLASSES-1:0] expected);
      @(negedge clk);
      pix_valid = 1'b0;
      pix       = '0;
      while (!out_valid) begin
         @(negedge clk);
      end
      check_value("out", 32'(out), 32'(expected));
      held_out = expected;
      img_cnt  = img_cnt + 1;
      // pulse lasts one cycle only
      @(negedge clk);
      check_value("out_valid", 32'(out_valid), 32'd0);
   endtask

   // --------------------
   // main sequence
   // --------------------

   initial begin
      int n_w;
      int n_p;
      int n_img;
      int row;
      rst          = 1'b1;
      pix_valid    = 1'b0;
      pix          = '0;
      wt_valid     = 1'b0;
      wt           = '0;
      held_out     = '0;
      pulse_cnt    = 0;
      img_cnt      = 0;
      check_cnt    = 0;
      limit_cycles = 0;
      n_w          = 0;
      n_p          = 0;
      n_img        = 0;
      row          = 0;
      read_trace();
      foreach (recs[i]) begin
         if (recs[i].kind == "w") n_w++;
         if (recs[i].kind == "p") n_p++;
         if (recs[i].kind == "e") n_img++;
      end
      limit_cycles = RST_CYCLES + n_img * IMG_CYCLES + 5 * n_w + 4 * n_p + 20;
      repeat (RST_CYCLES) @(negedge clk);
      rst = 1'b0;
      @(negedge clk);
      // reset state of the outputs
      check_value("out", 32'(out), 32'd0);
      check_value("out_valid", 32'(out_valid), 32'd0);
      check_value("busy", 32'(busy), 32'd0);
      foreach (recs[i]) begin
         case (recs[i].kind)
            "w": load_weight_row(recs[i]);
            "p": begin
               if (row == 0) begin
                  check_image_start();
               end
               send_pixel_row(recs[i]);
               row++;
            end
            "e": begin
               collect_result(recs[i].a[`CNN_CLASSES-1:0]);
               row = 0;
            end
            default: stop_with_error("bad record kind in trace queue");
         endcase
      end
      // let any stray pulse show up in the count
      repeat (5) @(negedge clk);
      if (img_cnt > 0 && check_cnt > 0 && pulse_cnt == img_cnt) begin
         $display("all tests passed");
         $finish;
      end else begin
         $display("%0d out_valid pulses for %0d images", pulse_cnt, img_cnt);
         $display("tests failed");
         $fatal(1, "run ended with missing or extra results");
      end
   end

   // --------------------
   // watchdog
   // --------------------

   initial begin
      wait (limit_cycles > 0);
      repeat (limit_cycles) @(posedge clk);
      $display("timeout: run did not finish within %0d cycles", limit_cycles);
      $display("tests failed");
      $fatal(1, "watchdog expired");
   end

endmodule

//--- tb/classifier_trace.txt
# w layer node tap0 tap1 tap2 tap3 : layer 0 is fc1, 1 is fc2, weights in hex Q8.8
# p pix0 pix1 pix2 pix3 : one raster row in hex Q8.8 ; e out : expected decision in hex
# fc1 identity
w 0 0 0100 0000 0000 0000
w 0 1 0000 0100 0000 0000
w 0 2 0000 0000 0100 0000
w 0 3 0000 0000 0000 0100
# fc2 first set
w 1 0 0100 0000 0000 0000
w 1 1 FF00 0000 0000 0000
w 1 2 0000 0000 0000 0100
w 1 3 0000 0000 0000 FF00
w 1 4 0100 0000 0000 FF00
w 1 5 FF00 0000 0000 0100
w 1 6 0000 0100 0000 0000
w 1 7 0000 FF00 FF00 0000
w 1 8 FE00 0100 0100 0100
w 1 9 0200 FF00 FF00 FF00
# ordinary image, pooled 3 -1 -5 4
p 0100 0200 FF00 FD00
p 0300 0000 FE00 FC00
p FB00 FA00 0400 0100
p F900 F800 0200 0000
e 11A
# fc2 reloaded with every weight negated
w 1 0 FF00 0000 0000 0000
w 1 1 0100 0000 0000 0000
w 1 2 0000 0000 0000 FF00
w 1 3 0000 0000 0000 0100
w 1 4 FF00 0000 0000 0100
w 1 5 0100 0000 0000 FF00
w 1 6 0000 FF00 0000 0000
w 1 7 0000 0100 0100 0000
w 1 8 0200 FF00 FF00 FF00
w 1 9 FE00 0100 0100 0100
# same image again
p 0100 0200 FF00 FD00
p 0300 0000 FE00 FC00
p FB00 FA00 0400 0100
p F900 F800 0200 0000
e 225
# one positive pixel per window, pooled 8 6 5 7
p FF00 0800 FE00 FD00
p FC00 FB00 FA00 0600
p 0500 FF00 FE00 FE00
p FD00 FC00 FF00 0700
e 155
# fc1 weights that push sums far past 16 bits
w 0 0 7F00 7F00 7F00 0000
w 0 1 8100 8100 8100 0000
w 0 2 0100 0000 0000 0000
w 0 3 0000 0000 0000 0000
# every window pools to 7000
p 7000 1000 0100 7000
p 2000 3000 7000 0000
p 7000 FF00 0200 0300
p 0400 0500 0600 7000
e 211

//--- build.f
+incdir+source
source/cnn_pkg.sv
source/max_pool_2x2.sv
source/flatten_buffer.sv
source/weight_store.sv
source/fc_engine.sv
source/class_decision.sv
source/cnn_classifier_top.sv
tb/tb_cnn_classifier.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the classifier testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f build.f --top-module tb_cnn_classifier

if ! sim_out=$(./obj_dir/Vtb_cnn_classifier); then
   printf '%s\n' "$sim_out"
   echo "simulation exited with an error"
   exit 1
fi
printf '%s\n' "$sim_out"

if grep -qx "all tests passed" <<< "$sim_out"; then
   echo "PASS"
else
   echo "FAIL"
   exit 1
fi
